// File: flist.f
source/rv_pkg.sv
source/instr_decoder.sv
source/register_file.sv
source/int_alu.sv
source/int_pipeline.sv
source/int_core.sv
verif/int_core_assert.sv
verif/int_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the core with its testbench, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module int_core_tb -f flist.f -o int_core_sim || { echo "build failed"; exit 1; }
sim_output="$(./obj_dir/int_core_sim 2>&1)"
echo "$sim_output"
echo "$sim_output" | grep -qx "Simulation completed successfully" \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }

// File: source/instr_decoder.sv
// ******************************
// instruction decoder for the kept RV32I forms
// ******************************
module instr_decoder import rv_pkg::*; (
    input  instr_word_t                instr,
    output alu_op_t                    alu_op,
    output logic [reg_index_width-1:0] rd,
    output logic [reg_index_width-1:0] rs1,
    output logic [reg_index_width-1:0] rs2,
    output logic [xlen-1:0]            imm,
    output logic                       use_imm,
    output logic                       illegal
);

    always_comb begin
        // defaults follow the register-register view
        alu_op  = alu_add;
        rd      = instr.r_type.rd;
        rs1     = instr.r_type.rs1;
        rs2     = instr.r_type.rs2;
        imm     = {{(xlen - 12){instr.i_type.imm12[11]}}, instr.i_type.imm12};
        use_imm = 1'b0;
        illegal = 1'b0;
        case (instr.r_type.opcode)
            opc_op: begin
                case (instr.r_type.funct3)
                    f3_add_sub: alu_op = instr.r_type.funct7[5] ? alu_sub : alu_add;
                    f3_sll:     alu_op = alu_sll;
                    f3_slt:     alu_op = alu_slt;
                    f3_sltu:    alu_op = alu_sltu;
                    f3_xor:     alu_op = alu_xor;
                    f3_srl_sra: alu_op = instr.r_type.funct7[5] ? alu_sra : alu_srl;
                    f3_or:      alu_op = alu_or;
                    default:    alu_op = alu_and;
                endcase
                // the alternate funct7 is only defined for sub and sra
                if (instr.r_type.funct7 == funct7_alt)
                    illegal = instr.r_type.funct3 != f3_add_sub
                           && instr.r_type.funct3 != f3_srl_sra;
                else if (instr.r_type.funct7 != '0)
                    illegal = 1'b1;
            end
            opc_op_imm: begin
                use_imm = 1'b1;
                // no second source, so keep it out of the forwarding compare
                rs2     = '0;
                case (instr.i_type.funct3)
                    f3_add_sub: alu_op = alu_add;
                    f3_sll:     alu_op = alu_sll;
                    f3_slt:     alu_op = alu_slt;
                    f3_sltu:    alu_op = alu_sltu;
                    f3_xor:     alu_op = alu_xor;
                    f3_srl_sra: alu_op = instr.i_type.imm12[10] ? alu_sra : alu_srl;
                    f3_or:      alu_op = alu_or;
                    default:    alu_op = alu_and;
                endcase
                // shift immediates keep the shift amount in the low five bits only
                if (instr.i_type.funct3 == f3_sll)
                    illegal = instr.i_type.imm12[11:5] != '0;
                else if (instr.i_type.funct3 == f3_srl_sra)
                    illegal = instr.i_type.imm12[11:5] != '0
                           && instr.i_type.imm12[11:5] != funct7_alt;
            end
            // anything else, including words without 2'b11 at the bottom
            default: illegal = 1'b1;
        endcase
    end

endmodule

// File: source/int_alu.sv
// ******************************
// integer ALU for add, sub, logic,
// compares and shifts
// ******************************
module int_alu import rv_pkg::*; (
    input  alu_op_t         op,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] result
);

    // shifts use only the low bits of the second operand
    logic [$clog2(xlen)-1:0] shamt;

    always_comb begin
        shamt = b[$clog2(xlen)-1:0];
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            // compares produce 0 or 1 in the low bit
            alu_slt:  result = {{(xlen - 1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: result = {{(xlen - 1){1'b0}}, a < b};
            alu_sll:  result = a << shamt;
            alu_srl:  result = a >> shamt;
            // the arithmetic shift copies the sign bit in from the top
            alu_sra:  result = $signed(a) >>> shamt;
            default:  result = '0;
        endcase
    end

endmodule

// File: source/int_core.sv
// ******************************
// top level of the integer core,
// pipeline beside its register file
// ******************************
module int_core import rv_pkg::*; (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       in_valid,
    input  instr_word_t                in_instr,
    output logic                       in_ready,
    output logic                       retire_valid,
    input  logic                       retire_ready,
    output logic [reg_index_width-1:0] retire_rd,
    output logic [xlen-1:0]            retire_value,
    output logic                       retire_illegal
);

    // register file read and write paths
    logic [reg_index_width-1:0] rs1_index, rs2_index, write_index;
    logic [xlen-1:0]            rs1_data, rs2_data, write_data;
    logic                       write_enable;

    int_pipeline pipe0 (
        .clock          (clock),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_instr       (in_instr),
        .in_ready       (in_ready),
        .retire_valid   (retire_valid),
        .retire_ready   (retire_ready),
        .retire_rd      (retire_rd),
        .retire_value   (retire_value),
        .retire_illegal (retire_illegal),
        .rs1_index      (rs1_index),
        .rs2_index      (rs2_index),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .write_enable   (write_enable),
        .write_index    (write_index),
        .write_data     (write_data)
    );

    register_file regs0 (
        .clock        (clock),
        .rs1_index    (rs1_index),
        .rs2_index    (rs2_index),
        .write_enable (write_enable),
        .write_index  (write_index),
        .write_data   (write_data),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

endmodule

// File: source/int_pipeline.sv
// ******************************
// decode, execute and retire stages with
// forwarding and valid/ready handshakes
// ******************************
module int_pipeline import rv_pkg::*; (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       in_valid,
    input  instr_word_t                in_instr,
    output logic                       in_ready,
    output logic                       retire_valid,
    input  logic                       retire_ready,
    output logic [reg_index_width-1:0] retire_rd,
    output logic [xlen-1:0]            retire_value,
    output logic                       retire_illegal,
    output logic [reg_index_width-1:0] rs1_index,
    output logic [reg_index_width-1:0] rs2_index,
    input  logic [xlen-1:0]            rs1_data,
    input  logic [xlen-1:0]            rs2_data,
    output logic                       write_enable,
    output logic [reg_index_width-1:0] write_index,
    output logic [xlen-1:0]            write_data
);

    // decode stage outputs, all combinational on the incoming word
    alu_op_t                    dec_op;
    logic [reg_index_width-1:0] dec_rd;
    logic [reg_index_width-1:0] dec_rs1;
    logic [reg_index_width-1:0] dec_rs2;
    logic [xlen-1:0]            dec_imm;
    logic                       dec_use_imm;
    logic                       dec_illegal;

    // execute stage register
    logic                       ex_valid;
    alu_op_t                    ex_op;
    logic [reg_index_width-1:0] ex_rd;
    logic [xlen-1:0]            ex_a;
    logic [xlen-1:0]            ex_b;
    logic                       ex_illegal;
    logic [xlen-1:0]            ex_result;

    logic retire_stall, accept, ex_fwd_ok, retire_fwd_ok;
    logic [xlen-1:0] rs1_value, rs2_value;

    instr_decoder decoder0 (
        .instr   (in_instr),
        .alu_op  (dec_op),
        .rd      (dec_rd),
        .rs1     (dec_rs1),
        .rs2     (dec_rs2),
        .imm     (dec_imm),
        .use_imm (dec_use_imm),
        .illegal (dec_illegal)
    );

    int_alu alu0 (
        .op     (ex_op),
        .a      (ex_a),
        .b      (ex_b),
        .result (ex_result)
    );

    always_comb begin
        // a full retire stage that is not being taken holds everything behind it
        retire_stall = retire_valid && !retire_ready;
        in_ready     = !(ex_valid && retire_stall);
        accept       = in_valid && in_ready;
        rs1_index    = dec_rs1;
        rs2_index    = dec_rs2;
        // only legal results headed for a real register may be forwarded
        ex_fwd_ok     = ex_valid && !ex_illegal && ex_rd != '0;
        retire_fwd_ok = retire_valid && !retire_illegal && retire_rd != '0;
        // the younger result in execute wins over the one waiting to retire
        if (ex_fwd_ok && ex_rd == dec_rs1)
            rs1_value = ex_result;
        else if (retire_fwd_ok && retire_rd == dec_rs1)
            rs1_value = retire_value;
        else
            rs1_value = rs1_data;
        if (ex_fwd_ok && ex_rd == dec_rs2)
            rs2_value = ex_result;
        else if (retire_fwd_ok && retire_rd == dec_rs2)
            rs2_value = retire_value;
        else
            rs2_value = rs2_data;
        // the register file is written only when a legal result leaves the core
        write_enable = retire_valid && retire_ready && !retire_illegal && retire_rd != '0;
        write_index  = retire_rd;
        write_data   = retire_value;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ex_valid     <= 1'b0;
            retire_valid <= 1'b0;
        end else begin
            if (in_ready)
                ex_valid <= in_valid;
            if (!retire_stall)
                retire_valid <= ex_valid;
        end
        // operands are captured at acceptance, already forwarded
        if (accept) begin
            ex_op      <= dec_op;
            ex_rd      <= dec_rd;
            ex_a       <= rs1_value;
            ex_b       <= dec_use_imm ? dec_imm : rs2_value;
            ex_illegal <= dec_illegal;
        end
        // the retire register refills when it is empty or draining this cycle
        if (ex_valid && !retire_stall) begin
            retire_rd      <= ex_rd;
            retire_value   <= ex_illegal ? '0 : ex_result;
            retire_illegal <= ex_illegal;
        end
    end

endmodule

// File: source/register_file.sv
// ******************************
// integer register file, x0 reads as zero
// ******************************
module register_file import rv_pkg::*; (
    input  logic                       clock,
    input  logic [reg_index_width-1:0] rs1_index,
    input  logic [reg_index_width-1:0] rs2_index,
    input  logic                       write_enable,
    input  logic [reg_index_width-1:0] write_index,
    input  logic [xlen-1:0]            write_data,
    output logic [xlen-1:0]            rs1_data,
    output logic [xlen-1:0]            rs2_data
);

    // x0 has no storage at all
    logic [xlen-1:0] regs [1:reg_count-1];

    always_ff @(posedge clock) begin
        if (write_enable && write_index != '0)
            regs[write_index] <= write_data;
    end

    // reads are combinational and see the old value during a write cycle
    always_comb begin
        rs1_data = (rs1_index == '0) ? '0 : regs[rs1_index];
        rs2_data = (rs2_index == '0) ? '0 : regs[rs2_index];
    end

endmodule

// File: source/rv_pkg.sv
// ******************************
// shared widths, opcode and funct constants,
// instruction word views and the ALU operation type
// ******************************
package rv_pkg;

    // the datapath is the plain RV32I integer width
    localparam int xlen = 32;
    localparam int reg_index_width = 5;
    localparam int reg_count = 32;

    // major opcodes, both of which carry the mandatory 2'b11 in the low bits
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;

    // funct3 encodings shared by the register and immediate forms
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct7 with bit 30 set turns add into sub and srl into sra
    localparam logic [6:0] funct7_alt = 7'b0100000;

    // register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    // register-immediate layout, where imm12 overlays funct7 and rs2
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // one 32-bit word seen through either layout
    typedef union packed {
        r_type_t r_type;
        i_type_t i_type;
    } instr_word_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
    } alu_op_t;

endpackage

// File: verif/int_core_assert.sv
// ******************************
// handshake and reset assertions,
// bound to the core top level
// ******************************
module int_core_assert import rv_pkg::*; (
    input logic                       clock,
    input logic                       reset,
    input logic                       in_ready,
    input logic                       retire_valid,
    input logic                       retire_ready,
    input logic [reg_index_width-1:0] retire_rd,
    input logic [xlen-1:0]            retire_value,
    input logic                       retire_illegal
);

    timeunit 1ns;
    timeprecision 100ps;

    // number of failed assertions so far
    int failures = 0;

    // the retire stage comes out of reset empty
    reset_clears_retire: assert property (@(posedge clock) reset |=> !retire_valid)
        else begin
            failures++;
            $error("retire_valid high in the cycle after reset");
        end

    // a result that is not taken stays put until it is
    retire_holds: assert property (@(posedge clock) disable iff (reset)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire_rd)
            && $stable(retire_value) && $stable(retire_illegal))
        else begin
            failures++;
            $error("retire outputs changed under back-pressure");
        end

    // with the retire stage empty nothing can block the input
    ready_when_empty: assert property (@(posedge clock) disable iff (reset)
        !retire_valid |-> in_ready)
        else begin
            failures++;
            $error("in_ready low while retire_valid is low");
        end

endmodule

bind int_core int_core_assert assert0 (
    .clock          (clock),
    .reset          (reset),
    .in_ready       (in_ready),
    .retire_valid   (retire_valid),
    .retire_ready   (retire_ready),
    .retire_rd      (retire_rd),
    .retire_value   (retire_value),
    .retire_illegal (retire_illegal)
);

// File: verif/int_core_tb.sv
// ******************************
// directed testbench for the integer core
// with reference model, scoreboard and watchdog
// ******************************
module int_core_tb import rv_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic                       clock;
    logic                       reset;
    logic                       in_valid;
    instr_word_t                in_instr;
    logic                       in_ready;
    logic                       retire_valid;
    logic                       retire_ready;
    logic [reg_index_width-1:0] retire_rd;
    logic [xlen-1:0]            retire_value;
    logic                       retire_illegal;

    // architectural state in program order, updated when a word is accepted
    logic [xlen-1:0] ref_regs [0:reg_count-1];
    // each entry packs {illegal, rd, value}
    logic [xlen+reg_index_width:0] expected [$];
    logic [31:0] ready_draw;
    logic        ready_random;
    int seed = 24345;
    int errors = 0;
    int checked = 0;
    int words_sent = 0;
    int cycle_count = 0;

    int_core dut0 (
        .clock          (clock),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_instr       (in_instr),
        .in_ready       (in_ready),
        .retire_valid   (retire_valid),
        .retire_ready   (retire_ready),
        .retire_rd      (retire_rd),
        .retire_value   (retire_value),
        .retire_illegal (retire_illegal)
    );

    always #5 clock = ~clock;

    // readiness is drawn on the rising edge and applied on the falling one
    always @(posedge clock) begin
        ready_draw = $random(seed);
    end

    always @(negedge clock) begin
        retire_ready = ready_random ? ready_draw[0] : 1'b1;
    end

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] i_word(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc_op_imm};
    endfunction

    // RV32I semantics for the kept forms, reading the reference registers
    function automatic void model_execute(input logic [31:0] w, output logic bad,
                                          output logic [31:0] value);
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic        is_imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        f7     = w[31:25];
        f3     = w[14:12];
        is_imm = w[6:0] == opc_op_imm;
        a      = ref_regs[w[19:15]];
        b      = is_imm ? {{20{w[31]}}, w[31:20]} : ref_regs[w[24:20]];
        sh     = b[4:0];
        value  = '0;
        bad    = 1'b0;
        if (w[6:0] != opc_op && !is_imm)
            bad = 1'b1;
        // bit 30 only means sub or sra, every other funct7 bit must be clear
        else if (!is_imm && f7 != 7'h00 && !(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
            bad = 1'b1;
        else if (is_imm && f3 == 3'd1 && f7 != 7'h00)
            bad = 1'b1;
        else if (is_imm && f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)
            bad = 1'b1;
        if (!bad) begin
            case (f3)
                3'd0: value = (!is_imm && f7[5]) ? a - b : a + b;
                3'd1: value = a << sh;
                3'd2: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: value = (a < b) ? 32'd1 : 32'd0;
                3'd4: value = a ^ b;
                3'd5: begin
                    if (f7[5])
                        value = $signed(a) >>> sh;
                    else
                        value = a >> sh;
                end
                3'd6: value = a | b;
                default: value = a & b;
            endcase
        end
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("Mismatch at %0d ns: %s expected %h actual %h", $time, name, exp, act);
    endtask

    // retire checks come before the model so one edge pops and pushes in order
    always @(posedge clock) begin : scoreboard
        logic [xlen+reg_index_width:0] entry;
        logic [31:0] word;
        logic [31:0] value;
        logic        bad;
        if (!reset && retire_valid && retire_ready) begin
            if (expected.size() == 0) begin
                errors++;
                $display("Error at %0d ns: a result retired with nothing outstanding", $time);
            end else begin
                entry = expected.pop_front();
                checked++;
                if (retire_illegal !== entry[37])
                    report_mismatch("retire_illegal", {31'b0, entry[37]}, {31'b0, retire_illegal});
                else if (!entry[37]) begin
                    if (retire_rd !== entry[36:32])
                        report_mismatch("retire_rd", {27'b0, entry[36:32]}, {27'b0, retire_rd});
                    if (retire_value !== entry[31:0])
                        report_mismatch("retire_value", entry[31:0], retire_value);
                end
            end
        end
        if (!reset && in_valid && in_ready) begin
            word = in_instr;
            model_execute(word, bad, value);
            expected.push_back({bad, word[11:7], value});
            if (!bad && word[11:7] != 5'd0)
                ref_regs[word[11:7]] = value;
        end
    end

    // called on a falling edge and returns on the falling edge after acceptance
    task automatic send_word(input logic [31:0] w);
        in_valid = 1'b1;
        in_instr = w;
        words_sent++;
        do @(posedge clock); while (!in_ready);
        @(negedge clock);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (expected.size() != 0)
            @(negedge clock);
        repeat (2) @(negedge clock);
    endtask

    task automatic check_reset();
        repeat (5) begin
            @(negedge clock);
            if (retire_valid !== 1'b0)
                report_mismatch("retire_valid", 32'd0, {31'b0, retire_valid});
            if (in_ready !== 1'b1)
                report_mismatch("in_ready", 32'd1, {31'b0, in_ready});
        end
        reset = 1'b0;
        repeat (3) begin
            @(negedge clock);
            if (retire_valid !== 1'b0)
                report_mismatch("retire_valid", 32'd0, {31'b0, retire_valid});
            if (in_ready !== 1'b1)
                report_mismatch("in_ready", 32'd1, {31'b0, in_ready});
        end
    endtask

    // the register file has no reset, so every register gets a known value first
    task automatic fill_registers();
        logic [4:0] idx;
        for (int i = 1; i < reg_count; i++) begin
            idx = i[4:0];
            send_word(i_word(f3_add_sub, idx, 5'd0, {2'b00, idx, idx} ^ 12'h5a5));
        end
        wait_drain();
    endtask

    task automatic test_arithmetic();
        logic [2:0]  f3;
        logic [11:0] imm;
        // x10 = -5, x11 = 3, x12 = 0x80000000, x13 = -1
        send_word(i_word(f3_add_sub, 5'd10, 5'd0, 12'hffb));
        send_word(i_word(f3_add_sub, 5'd11, 5'd0, 12'd3));
        send_word(i_word(f3_add_sub, 5'd12, 5'd0, 12'd1));
        send_word(i_word(f3_sll, 5'd12, 5'd12, 12'd31));
        send_word(i_word(f3_add_sub, 5'd13, 5'd0, 12'hfff));
        for (int f = 0; f < 8; f++) begin
            f3 = f[2:0];
            send_word(r_word(7'h00, f3, 5'd20, 5'd10, 5'd11));
            send_word(r_word(7'h00, f3, 5'd21, 5'd12, 5'd10));
            if (f3 == f3_add_sub || f3 == f3_srl_sra) begin
                send_word(r_word(funct7_alt, f3, 5'd22, 5'd12, 5'd11));
                send_word(r_word(funct7_alt, f3, 5'd22, 5'd10, 5'd13));
                send_word(i_word(f3, 5'd23, 5'd12, {funct7_alt, 5'd7}));
            end
            imm = (f3 == f3_sll || f3 == f3_srl_sra) ? 12'd13 : 12'h800;
            send_word(i_word(f3, 5'd24, 5'd10, imm));
            imm = (f3 == f3_sll || f3 == f3_srl_sra) ? 12'd1 : 12'h7ff;
            send_word(i_word(f3, 5'd25, 5'd12, imm));
        end
        wait_drain();
    endtask

    task automatic test_forwarding();
        send_word(i_word(f3_add_sub, 5'd1, 5'd0, 12'd7));
        send_word(i_word(f3_add_sub, 5'd2, 5'd1, 12'd3));
        send_word(r_word(7'h00, f3_add_sub, 5'd3, 5'd2, 5'd1));
        send_word(r_word(funct7_alt, f3_add_sub, 5'd4, 5'd3, 5'd2));
        send_word(r_word(7'h00, f3_sll, 5'd5, 5'd4, 5'd1));
        // two writes to x1 in flight, the younger one must win
        send_word(i_word(f3_add_sub, 5'd1, 5'd1, 12'd1));
        send_word(i_word(f3_add_sub, 5'd1, 5'd1, 12'd1));
        send_word(r_word(7'h00, f3_add_sub, 5'd6, 5'd1, 5'd5));
        send_word(r_word(7'h00, f3_xor, 5'd7, 5'd6, 5'd6));
        send_word(r_word(7'h00, f3_or, 5'd8, 5'd7, 5'd1));
        for (int i = 0; i < 10; i++)
            send_word(r_word(7'h00, f3_add_sub, 5'd9, 5'd9, 5'd8));
        wait_drain();
    endtask

    task automatic test_backpressure();
        logic [4:0] dst;
        logic [4:0] src;
        ready_random = 1'b1;
        for (int i = 0; i < 40; i++) begin
            dst = 5'd1 + 5'(i % 7);
            src = 5'd1 + 5'((i + 6) % 7);
            send_word(i_word(f3_add_sub, dst, src, 12'(i)));
        end
        wait_drain();
        ready_random = 1'b0;
    endtask

    task automatic test_illegal_x0();
        send_word(32'h0000_0000);
        send_word(32'hffff_ffff);
        send_word(32'h0000_2083);
        send_word(r_word(7'h01, f3_add_sub, 5'd1, 5'd2, 5'd3));
        send_word(r_word(funct7_alt, f3_and, 5'd1, 5'd2, 5'd3));
        send_word(i_word(f3_sll, 5'd1, 5'd2, {funct7_alt, 5'd3}));
        send_word(i_word(f3_srl_sra, 5'd1, 5'd2, {7'h10, 5'd1}));
        send_word({25'h0000_0a0, 7'b0110010});
        // x1 must still hold its earlier value
        send_word(r_word(7'h00, f3_add_sub, 5'd14, 5'd1, 5'd0));
        send_word(i_word(f3_add_sub, 5'd0, 5'd0, 12'd123));
        send_word(r_word(7'h00, f3_add_sub, 5'd0, 5'd1, 5'd1));
        send_word(r_word(7'h00, f3_or, 5'd15, 5'd0, 5'd0));
        send_word(r_word(7'h00, f3_add_sub, 5'd16, 5'd0, 5'd1));
        wait_drain();
    endtask

    task automatic test_random_mix();
        logic [31:0] rnd;
        logic [31:0] word;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        ready_random = 1'b1;
        for (int n = 0; n < 200; n++) begin
            rnd = $random(seed);
            f3  = rnd[10:8];
            alt = rnd[20] && (f3 == f3_add_sub || f3 == f3_srl_sra);
            if (rnd[2:0] == 3'd0) begin
                // a raw word, nearly always illegal
                word = $random(seed);
            end else if (rnd[3]) begin
                word = r_word(alt ? funct7_alt : 7'h00, f3, {2'b00, rnd[13:11]},
                              {2'b00, rnd[16:14]}, {2'b00, rnd[19:17]});
            end else begin
                imm = rnd[31:20];
                if (f3 == f3_sll || f3 == f3_srl_sra)
                    imm = {alt ? funct7_alt : 7'h00, rnd[24:20]};
                word = i_word(f3, {2'b00, rnd[13:11]}, {2'b00, rnd[16:14]}, imm);
            end
            if (rnd[5:4] == 2'b00)
                @(negedge clock);
            send_word(word);
        end
        wait_drain();
        ready_random = 1'b0;
    endtask

    // the budget grows with every word handed to the core
    initial begin : watchdog
        while (cycle_count <= 20 * words_sent + 200) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with %0d words sent", cycle_count, words_sent);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_instr     = '0;
        retire_ready = 1'b1;
        ready_random = 1'b0;
        for (int i = 0; i < reg_count; i++)
            ref_regs[i] = '0;
        check_reset();
        fill_registers();
        test_arithmetic();
        test_forwarding();
        test_backpressure();
        test_illegal_x0();
        test_random_mix();
        if (checked != words_sent) begin
            errors++;
            $display("Error: %0d words sent but %0d results checked", words_sent, checked);
        end
        $display("Checked %0d results, %0d errors, %0d assertion failures",
                 checked, errors, dut0.assert0.failures);
        if (errors == 0 && dut0.assert0.failures == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
